//--- Makefile
# Verilator flow for the rename unit testbench

VERILATOR  ?= verilator
TOP        := tb_rename_unit
FILELIST   := sources.f
LINT_FLAGS := --lint-only --timing --assert -Wno-fatal
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only when the log holds the pass line
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- hdl/free_list.sv
`timescale 1ns/1ps

`include "rename_defs.svh"

module free_list
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      arst_n,
    input  logic      alloc_en,
    input  logic      recover_en,
    input  logic      rt_valid,
    input  phys_tag_t rt_new_tag,
    input  phys_tag_t rt_old_tag,
    output phys_tag_t alloc_tag,
    output logic      free_empty
);

    // Speculative free vector, used for allocation
    tag_vec_t spec_free;
    // Free vector of the committed state
    tag_vec_t arch_free;
    tag_vec_t arch_free_next;

    ////////////////////////////////////////////////////////////////////////////
    // Allocation
    ////////////////////////////////////////////////////////////////////////////

    // Lowest free tag wins, scan from the top
    always_comb begin
        alloc_tag = '0;
        for (int i = `RN_PHYS_REGS - 1; i >= 0; i--) begin
            if (spec_free[i]) begin
                alloc_tag = phys_tag_t'(i);
            end
        end
    end

    assign free_empty = ~|spec_free;

    ////////////////////////////////////////////////////////////////////////////
    // Retirement in the committed vector
    ////////////////////////////////////////////////////////////////////////////

    // Old mapping freed, new mapping now committed
    always_comb begin
        arch_free_next = arch_free;
        if (rt_valid) begin
            arch_free_next[rt_old_tag] = 1'b1;
            arch_free_next[rt_new_tag] = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Vector storage
    ////////////////////////////////////////////////////////////////////////////

    // Tags below the architectural count hold the reset mapping
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RN_PHYS_REGS; i++) begin
                spec_free[i] <= (i >= `RN_ARCH_REGS);
                arch_free[i] <= (i >= `RN_ARCH_REGS);
            end
        end else begin
            arch_free <= arch_free_next;
            if (recover_en) begin
                spec_free <= arch_free_next;
            end else begin
                // Allocated tag and retired tag never coincide
                if (alloc_en) begin
                    spec_free[alloc_tag] <= 1'b0;
                end
                if (rt_valid) begin
                    spec_free[rt_old_tag] <= 1'b1;
                end
            end
        end
    end

endmodule

//--- hdl/map_table.sv
`timescale 1ns/1ps

`include "rename_defs.svh"

module map_table
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      arst_n,
    input  logic      alloc_en,
    input  logic      recover_en,
    input  logic      rt_valid,
    input  arch_idx_t rn_dst,
    input  arch_idx_t rn_src1,
    input  arch_idx_t rn_src2,
    input  arch_idx_t rt_arch,
    input  phys_tag_t alloc_tag,
    input  phys_tag_t rt_new_tag,
    output phys_tag_t rn_dst_tag,
    output phys_tag_t rn_src1_tag,
    output phys_tag_t rn_src2_tag,
    output phys_tag_t rn_old_tag,
    output phys_tag_t rt_old_tag
);

    // Speculative map, updated at rename
    phys_tag_t spec_map [`RN_ARCH_REGS];
    // Architectural map, updated at retire
    phys_tag_t arch_map [`RN_ARCH_REGS];
    // Architectural map with this cycle's retire applied
    phys_tag_t arch_next [`RN_ARCH_REGS];

    ////////////////////////////////////////////////////////////////////////////
    // Retire path
    ////////////////////////////////////////////////////////////////////////////

    // Tag displaced from the committed state, goes back to the free list
    assign rt_old_tag = arch_map[rt_arch];

    always_comb begin
        arch_next = arch_map;
        if (rt_valid) begin
            arch_next[rt_arch] = rt_new_tag;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Map storage
    ////////////////////////////////////////////////////////////////////////////

    // Identity mapping out of reset
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                spec_map[i] <= phys_tag_t'(i);
                arch_map[i] <= phys_tag_t'(i);
            end
        end else begin
            arch_map <= arch_next;
            // Recovery takes the committed map, including a retire in the same cycle
            if (recover_en) begin
                spec_map <= arch_next;
            end else if (alloc_en) begin
                spec_map[rn_dst] <= alloc_tag;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Rename result
    ////////////////////////////////////////////////////////////////////////////

    // Lookups see the map before this request's own update
    // so a source equal to the destination gets the old tag
    always_ff @(posedge clock) begin
        if (alloc_en) begin
            rn_dst_tag  <= alloc_tag;
            rn_src1_tag <= spec_map[rn_src1];
            rn_src2_tag <= spec_map[rn_src2];
            rn_old_tag  <= spec_map[rn_dst];
        end
    end

endmodule

//--- hdl/rename_ctrl.sv
`timescale 1ns/1ps

module rename_ctrl
    import rename_pkg::*;
(
    input  logic clock,
    input  logic arst_n,
    input  logic rn_valid,
    input  logic flush,
    input  logic free_empty,
    output logic rn_ready,
    output logic alloc_en,
    output logic recover_en,
    output logic rn_out_valid
);

    rename_state_t state;
    rename_state_t state_next;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake
    ////////////////////////////////////////////////////////////////////////////

    // Ready only in normal running with a tag left
    // A flush in the same cycle blocks the request
    assign rn_ready = (state == RN_RUN) && !flush && !free_empty;

    // Accepting edge
    assign alloc_en = rn_valid && rn_ready;

    // Datapath restores its copies during the recovery cycle
    assign recover_en = (state == RN_RECOVER);

    ////////////////////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////////////////////

    // One recovery cycle per flush
    // A flush seen while recovering starts another one
    always_comb begin
        state_next = RN_RUN;
        if (flush) begin
            state_next = RN_RECOVER;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            state        <= RN_RUN;
            rn_out_valid <= 1'b0;
        end else begin
            state        <= state_next;
            // Result valid one cycle after acceptance
            rn_out_valid <= alloc_en;
        end
    end

endmodule

//--- hdl/rename_defs.svh
`ifndef RENAME_DEFS_SVH
`define RENAME_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// Register file sizes
////////////////////////////////////////////////////////////////////////////

// Architectural registers, all renamed
`define RN_ARCH_REGS 32
// Physical tags in the pool
`define RN_PHYS_REGS 64

// Index and tag widths
`define RN_ARCH_W 5
`define RN_TAG_W 6

`endif

//--- hdl/rename_pkg.sv
`include "rename_defs.svh"

package rename_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Rename datapath types
    ////////////////////////////////////////////////////////////////////////////

    // Architectural register index
    typedef logic [`RN_ARCH_W-1:0] arch_idx_t;

    // Physical register tag
    typedef logic [`RN_TAG_W-1:0] phys_tag_t;

    // One bit per physical tag, set when free
    typedef logic [`RN_PHYS_REGS-1:0] tag_vec_t;

    // Controller state
    typedef enum logic [0:0] {
        RN_RUN     = 1'b0,
        RN_RECOVER = 1'b1
    } rename_state_t;

endpackage

//--- hdl/rename_unit.sv
`timescale 1ns/1ps

module rename_unit
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      arst_n,
    // Rename request
    input  logic      rn_valid,
    input  arch_idx_t rn_dst,
    input  arch_idx_t rn_src1,
    input  arch_idx_t rn_src2,
    output logic      rn_ready,
    // Rename result, one cycle after acceptance
    output logic      rn_out_valid,
    output phys_tag_t rn_dst_tag,
    output phys_tag_t rn_src1_tag,
    output phys_tag_t rn_src2_tag,
    output phys_tag_t rn_old_tag,
    // In-order retirement
    input  logic      rt_valid,
    input  arch_idx_t rt_arch,
    input  phys_tag_t rt_new_tag,
    // Recovery request
    input  logic      flush
);

    ////////////////////////////////////////////////////////////////////////////
    // Internal wiring
    ////////////////////////////////////////////////////////////////////////////

    logic      alloc_en;
    logic      recover_en;
    logic      free_empty;
    phys_tag_t alloc_tag;
    // Committed tag displaced by a retire
    phys_tag_t rt_old_tag;

    // Handshake and recovery sequencing
    rename_ctrl rename_ctrl_inst (
        .clock        (clock),
        .arst_n       (arst_n),
        .rn_valid     (rn_valid),
        .flush        (flush),
        .free_empty   (free_empty),
        .rn_ready     (rn_ready),
        .alloc_en     (alloc_en),
        .recover_en   (recover_en),
        .rn_out_valid (rn_out_valid)
    );

    // Speculative and committed maps
    map_table map_table_inst (
        .clock       (clock),
        .arst_n      (arst_n),
        .alloc_en    (alloc_en),
        .recover_en  (recover_en),
        .rt_valid    (rt_valid),
        .rn_dst      (rn_dst),
        .rn_src1     (rn_src1),
        .rn_src2     (rn_src2),
        .rt_arch     (rt_arch),
        .alloc_tag   (alloc_tag),
        .rt_new_tag  (rt_new_tag),
        .rn_dst_tag  (rn_dst_tag),
        .rn_src1_tag (rn_src1_tag),
        .rn_src2_tag (rn_src2_tag),
        .rn_old_tag  (rn_old_tag),
        .rt_old_tag  (rt_old_tag)
    );

    // Tag pool
    free_list free_list_inst (
        .clock      (clock),
        .arst_n     (arst_n),
        .alloc_en   (alloc_en),
        .recover_en (recover_en),
        .rt_valid   (rt_valid),
        .rt_new_tag (rt_new_tag),
        .rt_old_tag (rt_old_tag),
        .alloc_tag  (alloc_tag),
        .free_empty (free_empty)
    );

endmodule

//--- sources.f
+incdir+hdl
hdl/rename_pkg.sv
hdl/rename_ctrl.sv
hdl/map_table.sv
hdl/free_list.sv
hdl/rename_unit.sv
test/rename_checker.sv
test/rename_assert.sv
test/tb_rename_unit.sv

//--- test/rename_assert.sv
`timescale 1ns/1ps

module rename_assert (
    input logic clock,
    input logic arst_n,
    input logic rn_valid,
    input logic rn_ready,
    input logic rn_out_valid,
    input logic flush
);

    // Failed assertions, read by the testbench at the end
    int fail_count = 0;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake and recovery timing
    ////////////////////////////////////////////////////////////////////////////

    // Result one cycle after an accepting edge
    result_after_accept: assert property (@(posedge clock) disable iff (!arst_n)
        (rn_valid && rn_ready) |=> rn_out_valid)
        else begin
            $error("rn_out_valid missing one cycle after acceptance");
            fail_count++;
        end

    // And never without one
    no_result_without_accept: assert property (@(posedge clock) disable iff (!arst_n)
        !(rn_valid && rn_ready) |=> !rn_out_valid)
        else begin
            $error("rn_out_valid without an accepting edge");
            fail_count++;
        end

    // Recovery cycle blocks requests
    not_ready_after_flush: assert property (@(posedge clock) disable iff (!arst_n)
        flush |=> !rn_ready)
        else begin
            $error("rn_ready high in the cycle after flush");
            fail_count++;
        end

    ready_known: assert property (@(posedge clock) disable iff (!arst_n)
        !$isunknown(rn_ready))
        else begin
            $error("rn_ready unknown after reset");
            fail_count++;
        end

endmodule

bind rename_unit rename_assert rename_assert_inst (
    .clock        (clock),
    .arst_n       (arst_n),
    .rn_valid     (rn_valid),
    .rn_ready     (rn_ready),
    .rn_out_valid (rn_out_valid),
    .flush        (flush)
);

//--- test/rename_checker.sv
`timescale 1ns/1ps

`include "rename_defs.svh"

module rename_checker
    import rename_pkg::*;
(
    input  logic      clock,
    input  logic      arst_n,
    input  logic      rn_valid,
    input  arch_idx_t rn_dst,
    input  arch_idx_t rn_src1,
    input  arch_idx_t rn_src2,
    input  logic      rn_ready,
    input  logic      rn_out_valid,
    input  phys_tag_t rn_dst_tag,
    input  phys_tag_t rn_src1_tag,
    input  phys_tag_t rn_src2_tag,
    input  phys_tag_t rn_old_tag,
    input  logic      rt_valid,
    input  arch_idx_t rt_arch,
    input  phys_tag_t rt_new_tag,
    input  logic      flush,
    output int        check_count,
    output int        mismatch_count
);

    // Model of both maps and both free vectors
    phys_tag_t spec_map [`RN_ARCH_REGS];
    phys_tag_t arch_map [`RN_ARCH_REGS];
    tag_vec_t  spec_free;
    tag_vec_t  arch_free;
    logic      recovering;
    // Result expected in the current cycle
    logic      pend_valid;
    phys_tag_t pend_dst;
    phys_tag_t pend_src1;
    phys_tag_t pend_src2;
    phys_tag_t pend_old;

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////

    // Expected new tag, both source tags and the replaced tag
    function automatic logic [4*`RN_TAG_W-1:0] predict_result(
        input arch_idx_t dst, input arch_idx_t src1, input arch_idx_t src2);
        int idx;
        idx = 0;
        // Walk up from tag 0 to the first free one
        while (idx < `RN_PHYS_REGS - 1 && !spec_free[idx]) begin
            idx++;
        end
        return {phys_tag_t'(idx), spec_map[src1], spec_map[src2], spec_map[dst]};
    endfunction

    task automatic compare(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            mismatch_count++;
            $display("CHECK FAILED time=%0t signal=%s expected=%0d actual=%0d",
                     $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Compare and update, on the values before each edge
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clock or negedge arst_n) begin
        logic      exp_ready;
        logic      accept;
        phys_tag_t old_arch;
        if (!arst_n) begin
            // Identity mapping, upper half free
            for (int i = 0; i < `RN_ARCH_REGS; i++) begin
                spec_map[i] = phys_tag_t'(i);
                arch_map[i] = phys_tag_t'(i);
            end
            for (int i = 0; i < `RN_PHYS_REGS; i++) begin
                spec_free[i] = (i >= `RN_ARCH_REGS);
                arch_free[i] = (i >= `RN_ARCH_REGS);
            end
            recovering     = 1'b0;
            pend_valid     = 1'b0;
            check_count    = 0;
            mismatch_count = 0;
        end else begin
            exp_ready = !recovering && !flush && (spec_free != '0);
            compare("rn_ready", exp_ready, rn_ready);
            compare("rn_out_valid", pend_valid, rn_out_valid);
            if (pend_valid) begin
                compare("rn_dst_tag", pend_dst, rn_dst_tag);
                compare("rn_src1_tag", pend_src1, rn_src1_tag);
                compare("rn_src2_tag", pend_src2, rn_src2_tag);
                compare("rn_old_tag", pend_old, rn_old_tag);
            end
            accept     = rn_valid && exp_ready;
            pend_valid = accept;
            if (accept) begin
                {pend_dst, pend_src1, pend_src2, pend_old} =
                    predict_result(rn_dst, rn_src1, rn_src2);
            end
            // Retire commits the new tag and frees the replaced one
            old_arch = arch_map[rt_arch];
            if (rt_valid) begin
                arch_map[rt_arch]     = rt_new_tag;
                arch_free[old_arch]   = 1'b1;
                arch_free[rt_new_tag] = 1'b0;
            end
            if (recovering) begin
                spec_map  = arch_map;
                spec_free = arch_free;
            end else begin
                if (accept) begin
                    spec_map[rn_dst]    = pend_dst;
                    spec_free[pend_dst] = 1'b0;
                end
                if (rt_valid) begin
                    spec_free[old_arch] = 1'b1;
                end
            end
            // One recovery cycle after each flush
            recovering = flush;
        end
    end

endmodule

//--- test/tb_rename_unit.sv
`timescale 1ns/1ps

module tb_rename_unit
    import rename_pkg::*;
();

    localparam int CLK_PERIOD      = 40;
    localparam int RESET_CYCLES    = 10;
    localparam int DIRECTED_CYCLES = 160;
    localparam int RANDOM_CYCLES   = 400;
    localparam int MARGIN_CYCLES   = 200;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES
                                     + MARGIN_CYCLES;

    logic      clock;
    logic      arst_n;
    logic      rn_valid;
    arch_idx_t rn_dst;
    arch_idx_t rn_src1;
    arch_idx_t rn_src2;
    logic      rn_ready;
    logic      rn_out_valid;
    phys_tag_t rn_dst_tag;
    phys_tag_t rn_src1_tag;
    phys_tag_t rn_src2_tag;
    phys_tag_t rn_old_tag;
    logic      rt_valid;
    arch_idx_t rt_arch;
    phys_tag_t rt_new_tag;
    logic      flush;
    int        check_count;
    int        mismatch_count;
    int        directed_errors;

    // ROB entries hold the architectural index and its new tag, oldest first
    logic [10:0] rob [$];
    arch_idx_t   pend_dst;

    rename_unit    rename_unit_inst (.*);
    rename_checker rename_checker_inst (.*);

    initial begin
        clock = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clock = ~clock;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired after %0d cycles without the run ending", WATCHDOG_CYCLES);
        $display("Regression failed");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // ROB stand-in
    ////////////////////////////////////////////////////////////////////////////

    // Results enter in order, flush squashes all
    always @(posedge clock) begin
        if (rn_out_valid) begin
            rob.push_back({pend_dst, rn_dst_tag});
        end
        if (flush) begin
            rob.delete();
        end
        if (rn_valid && rn_ready) begin
            pend_dst = rn_dst;
        end
    end

    // One cycle of stimulus, retire pops the oldest entry
    task automatic step(input logic req, input arch_idx_t dst, input arch_idx_t src1,
                        input arch_idx_t src2, input logic retire, input logic fl,
                        output logic taken);
        @(negedge clock);
        rn_valid = req;
        rn_dst   = dst;
        rn_src1  = src1;
        rn_src2  = src2;
        rt_valid = 1'b0;
        if (retire && rob.size() > 0) begin
            rt_valid = 1'b1;
            {rt_arch, rt_new_tag} = rob.pop_front();
        end
        flush = fl;
        @(posedge clock);
        taken = req && rn_ready;
    endtask

    // Held until accepted
    task automatic rename_hold(input arch_idx_t dst, input arch_idx_t src1,
                               input arch_idx_t src2);
        logic taken;
        taken = 1'b0;
        while (!taken) begin
            step(1'b1, dst, src1, src2, 1'b0, 1'b0, taken);
        end
    endtask

    task automatic idle(input int cycles, input logic retire);
        logic taken;
        repeat (cycles) begin
            step(1'b0, '0, '0, '0, retire, 1'b0, taken);
        end
    endtask

    task automatic expect_value(input string name, input int expected, input int actual);
        if (expected != actual) begin
            directed_errors++;
            $display("CHECK FAILED time=%0t signal=%s expected=%0d actual=%0d",
                     $time, name, expected, actual);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Sequences
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic      taken;
        logic      held;
        arch_idx_t hd;
        arch_idx_t h1;
        arch_idx_t h2;
        int        total;
        void'($urandom(32'h3b18_2ea8));
        arst_n          = 1'b0;
        rn_valid        = 1'b0;
        rn_dst          = '0;
        rn_src1         = '0;
        rn_src2         = '0;
        rt_valid        = 1'b0;
        rt_arch         = '0;
        rt_new_tag      = '0;
        flush           = 1'b0;
        directed_errors = 0;
        repeat (RESET_CYCLES) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;

        // First rename takes tag 32
        rename_hold(5'd5, 5'd3, 5'd7);
        idle(1, 1'b0);
        expect_value("rn_out_valid", 1, rn_out_valid);
        expect_value("rn_dst_tag", 32, rn_dst_tag);
        expect_value("rn_src1_tag", 3, rn_src1_tag);
        expect_value("rn_src2_tag", 7, rn_src2_tag);
        expect_value("rn_old_tag", 5, rn_old_tag);

        // Dependent chain, last reads its own destination
        rename_hold(5'd1, 5'd5, 5'd3);
        rename_hold(5'd2, 5'd1, 5'd5);
        rename_hold(5'd2, 5'd2, 5'd1);
        idle(1, 1'b0);
        while (rob.size() > 0) begin
            idle(1, 1'b1);
        end

        // Exhaust the free list
        for (int i = 0; i < 32; i++) begin
            rename_hold(arch_idx_t'(i), arch_idx_t'(i + 1), arch_idx_t'(31 - i));
        end
        repeat (6) begin
            step(1'b1, 5'd9, 5'd4, 5'd4, 1'b0, 1'b0, taken);
            expect_value("rn_ready", 0, taken);
        end
        // A retire frees one tag for the held request
        step(1'b1, 5'd9, 5'd4, 5'd4, 1'b1, 1'b0, taken);
        rename_hold(5'd9, 5'd4, 5'd4);

        // Freed tags reused lowest first
        idle(3, 1'b1);
        rename_hold(5'd10, 5'd9, 5'd0);
        rename_hold(5'd11, 5'd10, 5'd1);
        rename_hold(5'd12, 5'd11, 5'd12);

        // Flush with a request held, then architectural tags
        step(1'b1, 5'd3, 5'd5, 5'd2, 1'b0, 1'b1, taken);
        expect_value("rn_ready", 0, taken);
        rename_hold(5'd3, 5'd5, 5'd2);
        rename_hold(5'd4, 5'd3, 5'd9);
        idle(2, 1'b0);

        // Random mix, a request stays until taken
        held = 1'b0;
        repeat (RANDOM_CYCLES) begin
            if (!held) begin
                hd   = arch_idx_t'($urandom);
                h1   = arch_idx_t'($urandom);
                h2   = arch_idx_t'($urandom);
                held = ($urandom % 4) != 0;
            end
            step(held, hd, h1, h2, ($urandom % 3) == 0, ($urandom % 50) == 0, taken);
            if (taken) begin
                held = 1'b0;
            end
        end
        idle(3, 1'b0);

        total = mismatch_count + directed_errors
                + rename_unit_inst.rename_assert_inst.fail_count;
        $display("checks %0d, mismatches %0d, directed errors %0d, assertion failures %0d",
                 check_count, mismatch_count, directed_errors,
                 rename_unit_inst.rename_assert_inst.fail_count);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
